//--- cholesky_top.f
verilog/chol_pkg.sv
verilog/fx_sqrt.sv
verilog/fx_divider.sv
verilog/chol_matrix_store.sv
verilog/chol_sequencer.sv
verilog/cholesky_top.sv
tb/tb_cholesky_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cholesky_top \
	-f cholesky_top.f --Mdir obj_dir -o sim_cholesky
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cholesky > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "Simulation log holds no result line"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- tb/tb_cholesky_top.sv
// Self-checking testbench for cholesky_top that loads test matrices, runs the core and checks L
`default_nettype none

module tb_cholesky_top;

	import chol_pkg::*;

	localparam int N        = 6;
	localparam int NCASES   = 8;
	localparam int K_IDENT  = 0; // Identity matrix
	localparam int K_DIAG   = 1; // Scaled diagonal d*I
	localparam int K_RAND   = 2; // A = L0*L0' from a random L0
	localparam int K_NEGPIV = 3; // Random A whose pivot in column 3 turns negative
	localparam int RUN_CYCLES = N * (27 + 4 + (N - 1) * 40) + N * N * N; // Bound for one run
	localparam longint WATCHDOG_T = longint'(NCASES) * (RUN_CYCLES + 100) * 20;
	localparam int DISTURB_AT = 40; // L_00 is already stored and a_21 is not yet updated

	// Case table with kind, scale and whether the run is disturbed while busy
	localparam int CASE_KIND [NCASES] = '{K_IDENT, K_DIAG, K_DIAG, K_RAND,
		K_RAND, K_RAND, K_NEGPIV, K_NEGPIV};
	localparam int CASE_SCALE [NCASES] = '{1, 3, 7, 1, 2, 3, 2, 1};
	localparam bit CASE_DISTURB [NCASES] = '{0, 0, 1, 0, 0, 1, 0, 1};

	logic  i;
	logic  rst_n;
	logic  wr_en;
	logic  start;
	logic  busy, done, pivot_err;
	idx_t  wr_row, wr_col, rd_row, rd_col;
	elem_t wr_data, rd_data;

	elem_t a_in [N][N]; // Lower triangle loaded into the DUT
	elem_t m [N][N];    // Expected store contents at done
	logic  exp_err;     // Expected pivot_err
	int    value_errs, flag_errs, other_errs;

	cholesky_top #(.N(N)) u_dut (
		.i(i), .rst_n(rst_n), .wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col),
		.wr_data(wr_data), .start(start), .busy(busy), .done(done),
		.pivot_err(pivot_err), .rd_row(rd_row), .rd_col(rd_col), .rd_data(rd_data)
	);

	always #10 i = ~i; // 20-unit clock period

	task automatic check_elem(input string name, input elem_t got, input elem_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			flag_errs++;
		end
	endtask

	// Greedy bit-by-bit search for the largest r with r*r <= x
	function automatic logic [63:0] floor_sqrt(input logic [63:0] x);
		logic [63:0] r;
		logic [63:0] t;
		r = '0;
		for (int b = ROOT_W - 1; b >= 0; b--) begin
			t = r | (64'd1 << b);
			if (t * t <= x)
				r = t;
		end
		return r;
	endfunction

	task automatic build_matrix(input int kind, input int scale);
		elem_t l0 [N][N];
		wide_t acc;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++) begin
				a_in[r][c] = '0;
				l0[r][c]   = '0;
			end
		if (kind == K_IDENT || kind == K_DIAG) begin
			for (int r = 0; r < N; r++)
				a_in[r][r] = (kind == K_IDENT) ? elem_t'(1 << FRAC_W) : elem_t'(scale << FRAC_W);
		end else begin
			for (int r = 0; r < N; r++)
				for (int c = 0; c <= r; c++)
					if (r == c) // Diagonal >= scale
						l0[r][c] = elem_t'((scale << FRAC_W) + int'($urandom & 32'hffff));
					else
						l0[r][c] = elem_t'(int'($urandom % (scale * 65536)) - scale * 32768);
			for (int r = 0; r < N; r++)
				for (int c = 0; c <= r; c++) begin
					acc = '0;
					for (int k = 0; k <= c; k++) // Row r times row c of L0
						acc = acc + wide_t'(l0[r][k]) * wide_t'(l0[c][k]);
					a_in[r][c] = elem_t'(acc >>> FRAC_W);
				end
			if (kind == K_NEGPIV)
				a_in[3][3] = -a_in[3][3]; // Pivot of column 3 goes below zero
		end
	endtask

	// Reference schedule in fixed point, stopping at the first pivot that is not positive
	task automatic run_model();
		logic [63:0] rad;
		elem_t       root;
		exp_err = 1'b0;
		m = a_in;
		for (int k = 0; k < N && !exp_err; k++) begin
			if (m[k][k] <= 0) begin
				exp_err = 1'b1;
			end else begin
				rad = 64'(m[k][k]) << FRAC_W; // Radical is the pivot times 2^FRAC_W
				root = elem_t'(floor_sqrt(rad));
				m[k][k] = root;
				for (int r = k + 1; r < N; r++)
					m[r][k] = elem_t'((wide_t'(m[r][k]) <<< FRAC_W) / wide_t'(root));
				for (int j = k + 1; j < N; j++)
					for (int r = j; r < N; r++)
						m[r][j] = m[r][j]
							- elem_t'((wide_t'(m[r][k]) * wide_t'(m[j][k])) >>> FRAC_W);
			end
		end
	endtask

	task automatic load_matrix();
		for (int r = 0; r < N; r++)
			for (int c = 0; c <= r; c++) begin
				@(negedge i);
				wr_en   = 1'b1;
				wr_row  = idx_t'(r);
				wr_col  = idx_t'(c);
				wr_data = a_in[r][c];
			end
		@(negedge i);
		wr_en = 1'b0;
	endtask

	// Starts a run, optionally pokes the DUT while busy, and waits for done
	task automatic run_dut(input bit disturb);
		int cycles;
		@(negedge i);
		start = 1'b1;
		@(negedge i);
		start = 1'b0;
		check_flag("busy after start", busy, 1'b1);
		if (disturb) begin
			repeat (DISTURB_AT) @(negedge i); // A restart here would read L_00 as the pivot
			wr_en   = 1'b1; // Host write and a second start, both to be ignored
			wr_row  = idx_t'(2);
			wr_col  = idx_t'(1);
			wr_data = 36'h5a5a5a5a5;
			start   = 1'b1;
			@(negedge i);
			wr_en = 1'b0;
			start = 1'b0;
			check_flag("busy during disturbance", busy, 1'b1);
		end
		cycles = 0;
		while (!done && cycles < RUN_CYCLES) begin
			@(negedge i);
			cycles++;
		end
		if (!done) begin
			$display("The done pulse did not arrive within %0d cycles", RUN_CYCLES);
			other_errs++;
		end else begin
			check_flag("pivot_err", pivot_err, exp_err);
			check_flag("busy after done", busy, 1'b0);
		end
	endtask

	task automatic compare_matrix(input int n);
		elem_t exp;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++) begin
				@(negedge i);
				rd_row = idx_t'(r);
				rd_col = idx_t'(c);
				#1;
				exp = (r >= c) ? m[r][c] : '0; // Upper triangle reads as zero
				check_elem($sformatf("case %0d rd_data[%0d][%0d]", n, r, c), rd_data, exp);
			end
	endtask

	initial begin
		#(WATCHDOG_T);
		$display("Watchdog expired before all test cases finished");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		i          = 1'b0;
		rst_n      = 1'b0;
		wr_en      = 1'b0;
		wr_row     = '0;
		wr_col     = '0;
		wr_data    = '0;
		start      = 1'b0;
		rd_row     = '0;
		rd_col     = '0;
		value_errs = 0;
		flag_errs  = 0;
		other_errs = 0;
		void'($urandom(32'hfbf52ff0));
		repeat (4) @(posedge i);
		@(negedge i);
		rst_n = 1'b1;
		check_flag("busy after reset", busy, 1'b0);
		check_flag("done after reset", done, 1'b0);
		check_flag("pivot_err after reset", pivot_err, 1'b0);
		for (int n = 0; n < NCASES; n++) begin
			build_matrix(CASE_KIND[n], CASE_SCALE[n]);
			run_model();
			load_matrix();
			run_dut(CASE_DISTURB[n]);
			compare_matrix(n);
		end
		$display("Errors: %0d value, %0d flag, %0d other", value_errs, flag_errs, other_errs);
		if (value_errs + flag_errs + other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/chol_matrix_store.sv
// In-place register array holding the input matrix and its factor, shared by the host and the sequencer
`default_nettype none

module chol_matrix_store #(
	parameter int N = 6
) (
	input  logic            i,
	input  logic            rst_n,
	input  logic            busy,
	input  logic            wr_en,
	input  chol_pkg::idx_t  wr_row,
	input  chol_pkg::idx_t  wr_col,
	input  chol_pkg::elem_t wr_data,
	input  chol_pkg::idx_t  rd_row,
	input  chol_pkg::idx_t  rd_col,
	output chol_pkg::elem_t rd_data,
	input  chol_pkg::idx_t  ra_row,
	input  chol_pkg::idx_t  ra_col,
	input  chol_pkg::idx_t  rb_row,
	input  chol_pkg::idx_t  rb_col,
	input  chol_pkg::idx_t  rc_row,
	input  chol_pkg::idx_t  rc_col,
	output chol_pkg::elem_t ra_data,
	output chol_pkg::elem_t rb_data,
	output chol_pkg::elem_t rc_data,
	input  logic            sw_en,
	input  chol_pkg::idx_t  sw_row,
	input  chol_pkg::idx_t  sw_col,
	input  chol_pkg::elem_t sw_data
);

	import chol_pkg::*;

	elem_t mem [N][N]; // Row-major, only the lower triangle is ever written

	// Upper triangle and out-of-range indices read as zero
	function automatic elem_t read_elem(input idx_t row, input idx_t col);
		read_elem = '0;
		if (row >= col && int'(row) < N)
			read_elem = mem[row][col];
	endfunction

	always_comb begin
		rd_data = read_elem(rd_row, rd_col); // Host read port
		ra_data = read_elem(ra_row, ra_col); // Element being updated or the pivot
		rb_data = read_elem(rb_row, rb_col); // L_ik
		rc_data = read_elem(rc_row, rc_col); // L_jk
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < N; r++)
				for (int c = 0; c < N; c++)
					mem[r][c] <= '0;
		end else if (busy) begin
			if (sw_en && int'(sw_row) < N && int'(sw_col) < N)
				mem[sw_row][sw_col] <= sw_data; // Sequencer owns the array during a run
		end else if (wr_en && int'(wr_row) < N && int'(wr_col) < N) begin
			mem[wr_row][wr_col] <= wr_data; // Host loads only while idle
		end
	end

	// The host loads the lower triangle only
	a_host_lower: assert property (@(posedge i) disable iff (!rst_n)
		(wr_en && !busy) |-> wr_row >= wr_col);

endmodule

`default_nettype wire

//--- verilog/chol_pkg.sv
// Fixed-point format, element and index types and the sequencer states, imported by the RTL and testbench
`default_nettype none

package chol_pkg;

	localparam int DATA_W = 36; // Signed element width
	localparam int FRAC_W = 16; // Fraction bits of every element
	localparam int ROOT_W = 26; // Half of the 52-bit radical
	localparam int MAX_N  = 8;  // Largest matrix order the index type can address

	// One matrix element in signed fixed point
	typedef logic signed [DATA_W-1:0] elem_t;

	// Full product of two elements and the shifted dividend
	typedef logic signed [2*DATA_W-1:0] wide_t;

	// Row or column index below MAX_N
	typedef logic [$clog2(MAX_N)-1:0] idx_t;

	// Column sequencer states
	typedef enum logic [2:0] {
		IDLE,      // Waiting for start
		PIVOT_RD,  // Pivot a_kk is read and tested
		SQRT_WAIT, // Root of the pivot in progress
		DIV_START, // Element a_ik is read and handed to the divider
		DIV_WAIT,  // Division of a_ik by L_kk in progress
		UPDATE,    // One trailing element per cycle gets its multiply-subtract
		NEXT_COL,  // Advance to the next column
		FINISH     // Raise done and drop busy
	} seq_state_t;

endpackage

`default_nettype wire

//--- verilog/chol_sequencer.sv
// Column-by-column FSM that drives the root, the divisions and the multiply-subtract update of the factor
`default_nettype none

module chol_sequencer #(
	parameter int N = 6
) (
	input  logic                                         i,
	input  logic                                         rst_n,
	input  logic                                         start,
	output logic                                         busy,
	output logic                                         done,
	output logic                                         pivot_err,
	output chol_pkg::idx_t                               ra_row,
	output chol_pkg::idx_t                               ra_col,
	output chol_pkg::idx_t                               rb_row,
	output chol_pkg::idx_t                               rb_col,
	output chol_pkg::idx_t                               rc_row,
	output chol_pkg::idx_t                               rc_col,
	input  chol_pkg::elem_t                              ra_data,
	input  chol_pkg::elem_t                              rb_data,
	input  chol_pkg::elem_t                              rc_data,
	output logic                                         sw_en,
	output chol_pkg::idx_t                               sw_row,
	output chol_pkg::idx_t                               sw_col,
	output chol_pkg::elem_t                              sw_data,
	output logic                                         sqrt_start,
	output logic [chol_pkg::DATA_W+chol_pkg::FRAC_W-1:0] sqrt_radical,
	input  logic                                         sqrt_done,
	input  logic [chol_pkg::ROOT_W-1:0]                  sqrt_root,
	output logic                                         div_start,
	output chol_pkg::wide_t                              div_dividend,
	output chol_pkg::elem_t                              div_divisor,
	input  logic                                         div_done,
	input  chol_pkg::elem_t                              div_quotient
);

	import chol_pkg::*;

	localparam idx_t LAST = idx_t'(N - 1); // Index of the last row and column

	seq_state_t state;
	idx_t       k_idx;    // Current column
	idx_t       i_idx;    // Row of the division or the update
	idx_t       j_idx;    // Column of the update
	elem_t      root_q;   // L_kk held as the divisor for the whole column
	logic       upd_vld;  // An updated element waits to be written
	idx_t       upd_row;
	idx_t       upd_col;
	elem_t      upd_val;  // Registered result of the multiply-subtract
	wide_t      prod;     // Full product L_ik * L_jk
	elem_t      upd_nxt;  // a_ij minus the rescaled product
	elem_t      root_ext; // Root zero-extended to an element
	logic       pivot_ok; // Pivot on port a is strictly positive

	// Port a follows the state, ports b and c always point at column k
	always_comb begin
		if (state == PIVOT_RD) begin
			ra_row = k_idx; // a_kk
			ra_col = k_idx;
		end else if (state == DIV_START) begin
			ra_row = i_idx; // a_ik
			ra_col = k_idx;
		end else begin
			ra_row = i_idx; // a_ij
			ra_col = j_idx;
		end
		rb_row = i_idx; // L_ik
		rb_col = k_idx;
		rc_row = j_idx; // L_jk
		rc_col = k_idx;
	end

	always_comb begin
		pivot_ok     = ra_data > 0;
		sqrt_start   = (state == PIVOT_RD) && pivot_ok; // Only a valid pivot is rooted
		sqrt_radical = {ra_data, {FRAC_W{1'b0}}};       // Pivot scaled by 2^FRAC_W
		div_start    = (state == DIV_START);
		div_dividend = wide_t'(ra_data) <<< FRAC_W;     // Element scaled by 2^FRAC_W
		div_divisor  = root_q;
		root_ext     = elem_t'({{(DATA_W-ROOT_W){1'b0}}, sqrt_root});
		prod         = wide_t'(rb_data) * wide_t'(rc_data);
		upd_nxt      = ra_data - elem_t'(prod >>> FRAC_W); // Wraps to DATA_W bits
	end

	// Root and quotient go straight to the store so the next reads see them
	always_comb begin
		if (state == SQRT_WAIT && sqrt_done) begin
			sw_en   = 1'b1;
			sw_row  = k_idx;
			sw_col  = k_idx;
			sw_data = root_ext;
		end else if (state == DIV_WAIT && div_done) begin
			sw_en   = 1'b1;
			sw_row  = i_idx;
			sw_col  = k_idx;
			sw_data = div_quotient;
		end else begin
			sw_en   = upd_vld; // Update results land one cycle after their operands
			sw_row  = upd_row;
			sw_col  = upd_col;
			sw_data = upd_val;
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			busy      <= 1'b0;
			done      <= 1'b0;
			pivot_err <= 1'b0;
			k_idx     <= '0;
			i_idx     <= '0;
			j_idx     <= '0;
			upd_vld   <= 1'b0;
		end else begin
			done    <= 1'b0;
			upd_vld <= (state == UPDATE);
			case (state)
				IDLE: if (start) begin
					busy      <= 1'b1;
					pivot_err <= 1'b0; // Error flag lives until the next run
					k_idx     <= '0;
					state     <= PIVOT_RD;
				end
				PIVOT_RD: begin
					if (pivot_ok) begin
						state <= SQRT_WAIT;
					end else begin
						pivot_err <= 1'b1; // Matrix is not positive definite
						state     <= FINISH;
					end
				end
				SQRT_WAIT: if (sqrt_done) begin
					if (k_idx == LAST) begin
						state <= FINISH; // Last column has no sub-diagonal
					end else begin
						i_idx <= k_idx + idx_t'(1);
						state <= DIV_START;
					end
				end
				DIV_START: state <= DIV_WAIT;
				DIV_WAIT: if (div_done) begin
					if (i_idx == LAST) begin
						i_idx <= k_idx + idx_t'(1); // Trailing triangle starts at (k+1, k+1)
						j_idx <= k_idx + idx_t'(1);
						state <= UPDATE;
					end else begin
						i_idx <= i_idx + idx_t'(1);
						state <= DIV_START;
					end
				end
				UPDATE: begin
					if (i_idx == LAST) begin
						if (j_idx == LAST) begin
							state <= NEXT_COL;
						end else begin
							j_idx <= j_idx + idx_t'(1);
							i_idx <= j_idx + idx_t'(1); // Each column restarts on its diagonal
						end
					end else begin
						i_idx <= i_idx + idx_t'(1);
					end
				end
				NEXT_COL: begin
					k_idx <= k_idx + idx_t'(1);
					state <= PIVOT_RD;
				end
				FINISH: begin
					busy  <= 1'b0;
					done  <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (state == SQRT_WAIT && sqrt_done)
			root_q <= root_ext;
		if (state == UPDATE) begin
			upd_row <= i_idx;
			upd_col <= j_idx;
			upd_val <= upd_nxt;
		end
	end

	// Every result of a run lands in the lower triangle
	a_write_lower: assert property (@(posedge i) disable iff (!rst_n) sw_en |-> sw_row >= sw_col);

	// Done never stretches over two cycles
	a_done_pulse: assert property (@(posedge i) disable iff (!rst_n) done |=> !done);

endmodule

`default_nettype wire

//--- verilog/cholesky_top.sv
// Top level of the Cholesky core, connecting the matrix store, the sequencer and both arithmetic units
`default_nettype none

module cholesky_top #(
	parameter int N = 6
) (
	input  logic            i,
	input  logic            rst_n,
	input  logic            wr_en,
	input  chol_pkg::idx_t  wr_row,
	input  chol_pkg::idx_t  wr_col,
	input  chol_pkg::elem_t wr_data,
	input  logic            start,
	output logic            busy,
	output logic            done,
	output logic            pivot_err,
	input  chol_pkg::idx_t  rd_row,
	input  chol_pkg::idx_t  rd_col,
	output chol_pkg::elem_t rd_data
);

	import chol_pkg::*;

	idx_t  ra_row, ra_col, rb_row, rb_col, rc_row, rc_col; // Sequencer read addresses
	elem_t ra_data, rb_data, rc_data;
	logic  sw_en;                                          // Sequencer write port
	idx_t  sw_row, sw_col;
	elem_t sw_data;
	logic  sqrt_start, sqrt_done;
	logic  [DATA_W+FRAC_W-1:0] sqrt_radical;
	logic  [ROOT_W-1:0] sqrt_root;
	logic  div_start, div_done;
	wide_t div_dividend;
	elem_t div_divisor, div_quotient;

	chol_matrix_store #(.N(N)) u_store (
		.i(i), .rst_n(rst_n), .busy(busy),
		.wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data),
		.rd_row(rd_row), .rd_col(rd_col), .rd_data(rd_data),
		.ra_row(ra_row), .ra_col(ra_col), .rb_row(rb_row), .rb_col(rb_col),
		.rc_row(rc_row), .rc_col(rc_col),
		.ra_data(ra_data), .rb_data(rb_data), .rc_data(rc_data),
		.sw_en(sw_en), .sw_row(sw_row), .sw_col(sw_col), .sw_data(sw_data)
	);

	chol_sequencer #(.N(N)) u_seq (
		.i(i), .rst_n(rst_n), .start(start),
		.busy(busy), .done(done), .pivot_err(pivot_err),
		.ra_row(ra_row), .ra_col(ra_col), .rb_row(rb_row), .rb_col(rb_col),
		.rc_row(rc_row), .rc_col(rc_col),
		.ra_data(ra_data), .rb_data(rb_data), .rc_data(rc_data),
		.sw_en(sw_en), .sw_row(sw_row), .sw_col(sw_col), .sw_data(sw_data),
		.sqrt_start(sqrt_start), .sqrt_radical(sqrt_radical),
		.sqrt_done(sqrt_done), .sqrt_root(sqrt_root),
		.div_start(div_start), .div_dividend(div_dividend), .div_divisor(div_divisor),
		.div_done(div_done), .div_quotient(div_quotient)
	);

	fx_sqrt u_sqrt (
		.i(i), .rst_n(rst_n), .start(sqrt_start), .radical(sqrt_radical),
		.done(sqrt_done), .root(sqrt_root)
	);

	fx_divider u_div (
		.i(i), .rst_n(rst_n), .start(div_start), .dividend(div_dividend),
		.divisor(div_divisor), .done(div_done), .quotient(div_quotient)
	);

endmodule

`default_nettype wire

//--- verilog/fx_divider.sv
// Iterative signed restoring divider that turns each sub-diagonal element into its column entry of L
`default_nettype none

module fx_divider (
	input  logic            i,
	input  logic            rst_n,
	input  logic            start,
	input  chol_pkg::wide_t dividend,
	input  chol_pkg::elem_t divisor,
	output logic            done,
	output chol_pkg::elem_t quotient
);

	import chol_pkg::*;

	localparam int CNT_W = $clog2(DATA_W); // Counts the 36 quotient bits

	typedef enum logic [1:0] {
		DV_IDLE, // Waiting for start
		DV_RUN,  // Shift-subtract iterations
		DV_FIX   // Sign of the result is applied
	} div_state_t;

	div_state_t          state;
	logic [CNT_W-1:0]    cnt;     // Quotient bits left after the current one
	logic [2*DATA_W-1:0] dvd_mag; // Magnitude of the incoming dividend
	logic [DATA_W-1:0]   dvs_mag; // Magnitude of the incoming divisor
	logic [DATA_W-1:0]   rem;     // Partial remainder, always below dvs
	logic [DATA_W-1:0]   quo;     // Low dividend bits shift out the top while quotient bits enter
	logic [DATA_W-1:0]   dvs;     // Divisor magnitude held for the run
	logic                neg;     // Result must be negated
	logic [DATA_W:0]     rem_sh;  // Remainder with the next dividend bit appended
	logic [DATA_W:0]     rem_dif; // Trial subtraction
	logic                take;    // Trial fits so the quotient bit is one

	always_comb begin
		dvd_mag = dividend[2*DATA_W-1] ? -dividend : dividend;
		dvs_mag = divisor[DATA_W-1] ? -divisor : divisor;
		rem_sh  = {rem, quo[DATA_W-1]};
		rem_dif = rem_sh - {1'b0, dvs};
		take    = rem_sh >= {1'b0, dvs};
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			state <= DV_IDLE;
			cnt   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				DV_IDLE: if (start) begin
					state <= DV_RUN; // Magnitudes were taken in the start cycle
					cnt   <= CNT_W'(DATA_W - 1);
				end
				DV_RUN: begin
					if (cnt == '0)
						state <= DV_FIX;
					else
						cnt <= cnt - 1'b1;
				end
				DV_FIX: begin
					state <= DV_IDLE;
					done  <= 1'b1; // Quotient register is loaded on this same edge
				end
				default: state <= DV_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (state == DV_IDLE && start) begin
			rem <= dvd_mag[2*DATA_W-1:DATA_W]; // High half must stay below the divisor
			quo <= dvd_mag[DATA_W-1:0];
			dvs <= dvs_mag;
			neg <= dividend[2*DATA_W-1] ^ divisor[DATA_W-1];
		end else if (state == DV_RUN) begin
			rem <= take ? rem_dif[DATA_W-1:0] : rem_sh[DATA_W-1:0];
			quo <= {quo[DATA_W-2:0], take};
		end else if (state == DV_FIX) begin
			quotient <= neg ? elem_t'(-quo) : elem_t'(quo); // Truncation toward zero
		end
	end

	// A zero root never reaches the divider because the pivot test stops the run first
	a_div_nonzero: assert property (@(posedge i) disable iff (!rst_n) start |-> divisor != '0);

	// One division at a time
	a_div_idle: assert property (@(posedge i) disable iff (!rst_n) start |-> state == DV_IDLE);

endmodule

`default_nettype wire

//--- verilog/fx_sqrt.sv
// Bit-serial non-restoring square root of the 52-bit radical, started by the sequencer for each pivot
`default_nettype none

module fx_sqrt (
	input  logic                                      i,
	input  logic                                      rst_n,
	input  logic                                      start,
	input  logic [chol_pkg::DATA_W+chol_pkg::FRAC_W-1:0] radical,
	output logic                                      done,
	output logic [chol_pkg::ROOT_W-1:0]               root
);

	import chol_pkg::*;

	localparam int RAD_W = DATA_W + FRAC_W; // 52-bit radical
	localparam int CNT_W = $clog2(ROOT_W);  // Counts the 26 iterations

	logic                    busy;    // An extraction is running
	logic [CNT_W-1:0]        cnt;     // Iterations left after the current one
	logic [RAD_W-1:0]        rad_sh;  // Radical, consumed two bits at a time from the top
	logic signed [ROOT_W+1:0] rem;    // Partial remainder, may go negative
	logic [ROOT_W-1:0]       q;       // Root bits found so far
	logic signed [ROOT_W+1:0] rem_sh; // Remainder with the next bit pair shifted in
	logic signed [ROOT_W+1:0] rem_nxt; // Remainder after this iteration

	always_comb begin
		rem_sh = {rem[ROOT_W-1:0], rad_sh[RAD_W-1 -: 2]}; // Shift in the next two radical bits
		if (rem[ROOT_W+1])
			rem_nxt = rem_sh + {q, 2'b11}; // Negative remainder so add back
		else
			rem_nxt = rem_sh - {q, 2'b01}; // Non-negative remainder so subtract the trial
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= 1'b0; // Done is a single-cycle pulse
			if (start && !busy) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(ROOT_W - 1);
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0; // Last root bit lands with this edge
					done <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (start && !busy) begin
			rad_sh <= radical;
			rem    <= '0;
			q      <= '0;
		end else if (busy) begin
			rad_sh <= rad_sh << 2;
			rem    <= rem_nxt;
			q      <= {q[ROOT_W-2:0], ~rem_nxt[ROOT_W+1]}; // New root bit is set when remainder >= 0
		end
	end

	assign root = q; // Holds the final root until the next start

	// The sequencer must wait for done before the next pivot
	a_no_restart: assert property (@(posedge i) disable iff (!rst_n) start |-> !busy);

endmodule

`default_nettype wire
